/* video_defines.svh */
//////////////////////////////
// video timing defines
// 640x480 frame numbers, bar width and border colour
//////////////////////////////

`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// horizontal timing in pixel clocks
`define H_ACTIVE    640
`define H_FRONT     16
`define H_SYNC      96
`define H_BACK      48
`define H_TOTAL     800

// vertical timing in lines
`define V_ACTIVE    480
`define V_FRONT     10
`define V_SYNC      2
`define V_BACK      33
`define V_TOTAL     525

// active level of hsync and vsync, low for 640x480
`define SYNC_POL    1'b0

// eight vertical bars across the active width
`define BAR_WIDTH   80

// frame border colour
`define BORDER_RGB  24'hFFFFFF

`endif

/* video_pkg.sv */
//////////////////////////////
// video types
// pixel position and colour types for the video path
//////////////////////////////

`default_nettype none

package video_pkg;

    // x or y position, wide enough for 800 clocks per line
    typedef logic [10:0] coord_t;

    // one colour component
    typedef logic [7:0] comp_t;

    // red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] rgb_t;

endpackage

`default_nettype wire

/* tmds_pkg.sv */
//////////////////////////////
// TMDS types
// symbol, disparity, encoder state and control symbols
//////////////////////////////

`default_nettype none

package tmds_pkg;

    typedef logic [9:0] tmds_sym_t;

    // running disparity, ones minus zeros
    typedef logic signed [4:0] disp_t;

    typedef enum logic {
        ENC_BLANK  = 1'b0,
        ENC_ACTIVE = 1'b1
    } enc_state_t;

    // control symbols, indexed by {c1, c0}
    localparam tmds_sym_t CTRL_00 = 10'b1101010100;
    localparam tmds_sym_t CTRL_01 = 10'b0010101011;
    localparam tmds_sym_t CTRL_10 = 10'b0101010100;
    localparam tmds_sym_t CTRL_11 = 10'b1010101011;

endpackage

`default_nettype wire

/* video_if.sv */
//////////////////////////////
// video stage bus
// sync, enable, position and pixel of one stage
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

interface video_if;

    logic               hsync;
    logic               vsync;
    logic               de;
    video_pkg::coord_t  x;
    video_pkg::coord_t  y;
    video_pkg::rgb_t    rgb;

    // stage that produces the video
    modport src (
        output hsync, vsync, de, x, y, rgb
    );

    // stage that consumes it
    modport snk (
        input  hsync, vsync, de, x, y, rgb
    );

endinterface

`default_nettype wire

/* video_sync_gen.sv */
//////////////////////////////
// video sync generator
// counts 800x525 frame, decodes
// syncs, enable and position
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "video_defines.svh"

module video_sync_gen (
    input  wire logic   clk,
    input  wire logic   rst,
    video_if.src        bus
);

    video_pkg::coord_t  x_cnt;
    video_pkg::coord_t  y_cnt;
    logic               x_last;
    logic               y_last;
    logic               hs_on;
    logic               vs_on;

    // end of line and end of frame
    assign x_last = (x_cnt == video_pkg::coord_t'(`H_TOTAL - 1));
    assign y_last = (y_cnt == video_pkg::coord_t'(`V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else begin
            if (x_last) begin
                x_cnt <= '0;
                // next line, wrap at frame end
                if (y_last) begin
                    y_cnt <= '0;
                end else begin
                    y_cnt <= y_cnt + video_pkg::coord_t'(1);
                end
            end else begin
                x_cnt <= x_cnt + video_pkg::coord_t'(1);
            end
        end
    end

    // sync pulses after the front porch
    assign hs_on = (x_cnt >= video_pkg::coord_t'(`H_ACTIVE + `H_FRONT)) &&
                   (x_cnt <  video_pkg::coord_t'(`H_ACTIVE + `H_FRONT + `H_SYNC));
    assign vs_on = (y_cnt >= video_pkg::coord_t'(`V_ACTIVE + `V_FRONT)) &&
                   (y_cnt <  video_pkg::coord_t'(`V_ACTIVE + `V_FRONT + `V_SYNC));

    assign bus.hsync = hs_on ? `SYNC_POL : ~`SYNC_POL;
    assign bus.vsync = vs_on ? `SYNC_POL : ~`SYNC_POL;

    // visible area only
    assign bus.de = (x_cnt < video_pkg::coord_t'(`H_ACTIVE)) &&
                    (y_cnt < video_pkg::coord_t'(`V_ACTIVE));

    assign bus.x = x_cnt;
    assign bus.y = y_cnt;

    // no colour yet at this stage
    assign bus.rgb = '0;

endmodule

`default_nettype wire

/* pattern_draw.sv */
//////////////////////////////
// pattern drawer
// colour bars with a white border,
// one register stage
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "video_defines.svh"

module pattern_draw (
    input  wire logic   clk,
    input  wire logic   rst,
    video_if.snk        in_bus,
    video_if.src        out_bus
);

    video_pkg::coord_t  bar_full;
    logic [2:0]         bar_idx;
    video_pkg::comp_t   red;
    video_pkg::comp_t   green;
    video_pkg::comp_t   blue;
    logic               on_border;
    video_pkg::rgb_t    colour;

    // bar number across the line
    assign bar_full = in_bus.x / video_pkg::coord_t'(`BAR_WIDTH);
    assign bar_idx  = bar_full[2:0];

    assign red   = bar_idx[2] ? 8'hFF : 8'h00;
    assign green = bar_idx[1] ? 8'hFF : 8'h00;
    assign blue  = bar_idx[0] ? 8'hFF : 8'h00;

    // outermost rows and columns of the visible area
    assign on_border = (in_bus.y == '0) ||
                       (in_bus.y == video_pkg::coord_t'(`V_ACTIVE - 1)) ||
                       (in_bus.x == '0) ||
                       (in_bus.x == video_pkg::coord_t'(`H_ACTIVE - 1));

    assign colour = !in_bus.de ? '0 :
                    on_border  ? video_pkg::rgb_t'(`BORDER_RGB) :
                    {red, green, blue};

    always_ff @(posedge clk) begin
        if (rst) begin
            out_bus.hsync <= ~`SYNC_POL;
            out_bus.vsync <= ~`SYNC_POL;
            out_bus.de    <= 1'b0;
            out_bus.rgb   <= '0;
        end else begin
            out_bus.hsync <= in_bus.hsync;
            out_bus.vsync <= in_bus.vsync;
            out_bus.de    <= in_bus.de;
            out_bus.rgb   <= colour;
        end
    end

    // position follows the controls
    always_ff @(posedge clk) begin
        out_bus.x   <= in_bus.x;
        out_bus.y   <= in_bus.y;
    end

endmodule

`default_nettype wire

/* tmds_encoder.sv */
//////////////////////////////
// TMDS encoder
// DVI 8b/10b with running disparity,
// control symbols in blanking
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tmds_encoder (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               de,
    input  wire video_pkg::comp_t   data,
    input  wire logic [1:0]         ctrl,
    output tmds_pkg::tmds_sym_t     sym
);

    logic [3:0]             n1_data;
    logic                   use_xnor;
    logic [8:0]             q_m;
    logic [3:0]             n1_qm;
    tmds_pkg::disp_t        diff_qm;
    tmds_pkg::disp_t        disp;
    tmds_pkg::disp_t        disp_cur;
    tmds_pkg::disp_t        disp_next;
    tmds_pkg::tmds_sym_t    sym_next;
    tmds_pkg::tmds_sym_t    ctrl_sym;
    tmds_pkg::enc_state_t   state;

    // transition minimising stage
    always_comb begin
        n1_data = '0;
        for (int i = 0; i < 8; i++) begin
            n1_data = n1_data + 4'(data[i]);
        end
        use_xnor = (n1_data > 4'd4) || ((n1_data == 4'd4) && !data[0]);
        q_m[0] = data[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
        end
        q_m[8] = ~use_xnor;
    end

    // ones minus zeros of q_m[7:0], i.e. 2*n1 - 8
    always_comb begin
        n1_qm = '0;
        for (int i = 0; i < 8; i++) begin
            n1_qm = n1_qm + 4'(q_m[i]);
        end
        diff_qm = tmds_pkg::disp_t'({n1_qm, 1'b0} - 5'd8);
    end

    // a fresh active period starts balanced
    assign disp_cur = (state == tmds_pkg::ENC_BLANK) ? '0 : disp;

    // DC balancing stage
    always_comb begin
        if ((disp_cur == '0) || (diff_qm == '0)) begin
            sym_next  = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            disp_next = q_m[8] ? (disp_cur + diff_qm) : (disp_cur - diff_qm);
        end else if (disp_cur[4] == diff_qm[4]) begin
            // same sign as the running disparity, invert
            sym_next  = {1'b1, q_m[8], ~q_m[7:0]};
            disp_next = disp_cur + tmds_pkg::disp_t'({3'b000, q_m[8], 1'b0}) - diff_qm;
        end else begin
            sym_next  = {1'b0, q_m[8], q_m[7:0]};
            disp_next = disp_cur - tmds_pkg::disp_t'({3'b000, ~q_m[8], 1'b0}) + diff_qm;
        end
    end

    // ctrl is {c1, c0}
    always_comb begin
        unique case (ctrl)
            2'b00:   ctrl_sym = tmds_pkg::CTRL_00;
            2'b01:   ctrl_sym = tmds_pkg::CTRL_01;
            2'b10:   ctrl_sym = tmds_pkg::CTRL_10;
            default: ctrl_sym = tmds_pkg::CTRL_11;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= tmds_pkg::ENC_BLANK;
            disp  <= '0;
            sym   <= tmds_pkg::CTRL_00;
        end else if (de) begin
            state <= tmds_pkg::ENC_ACTIVE;
            disp  <= disp_next;
            sym   <= sym_next;
        end else begin
            state <= tmds_pkg::ENC_BLANK;
            sym   <= ctrl_sym;
        end
    end

endmodule

`default_nettype wire

/* hdmi_sample_top.sv */
//////////////////////////////
// HDMI sample video path
// sync generator, pattern drawer
// and three TMDS encoders
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module hdmi_sample_top (
    input  wire logic               clk,
    input  wire logic               rst,
    output logic                    draw_hsync,
    output logic                    draw_vsync,
    output logic                    draw_de,
    output video_pkg::rgb_t         draw_rgb,
    output tmds_pkg::tmds_sym_t     tmds_ch0,
    output tmds_pkg::tmds_sym_t     tmds_ch1,
    output tmds_pkg::tmds_sym_t     tmds_ch2
);

    video_if sync_bus ();
    video_if draw_bus ();

    video_sync_gen u_syncgen (
        .clk    (clk),
        .rst    (rst),
        .bus    (sync_bus)
    );

    pattern_draw u_draw (
        .clk        (clk),
        .rst        (rst),
        .in_bus     (sync_bus),
        .out_bus    (draw_bus)
    );

    assign draw_hsync = draw_bus.hsync;
    assign draw_vsync = draw_bus.vsync;
    assign draw_de    = draw_bus.de;
    assign draw_rgb   = draw_bus.rgb;

    // blue carries the syncs
    tmds_encoder u_enc0 (
        .clk    (clk),
        .rst    (rst),
        .de     (draw_bus.de),
        .data   (draw_bus.rgb[7:0]),
        .ctrl   ({draw_bus.vsync, draw_bus.hsync}),
        .sym    (tmds_ch0)
    );

    tmds_encoder u_enc1 (
        .clk    (clk),
        .rst    (rst),
        .de     (draw_bus.de),
        .data   (draw_bus.rgb[15:8]),
        .ctrl   (2'b00),
        .sym    (tmds_ch1)
    );

    tmds_encoder u_enc2 (
        .clk    (clk),
        .rst    (rst),
        .de     (draw_bus.de),
        .data   (draw_bus.rgb[23:16]),
        .ctrl   (2'b00),
        .sym    (tmds_ch2)
    );

endmodule

`default_nettype wire

/* tb_clock.sv */
//////////////////////////////
// testbench clock
// free running clock, 4 ns period
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD_NS = 2
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD_NS) clk = ~clk;

endmodule

`default_nettype wire

/* tb_hdmi_assertions.sv */
//////////////////////////////
// TMDS encoder assertions
// disparity range and control
// symbols during blanking
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tmds_encoder_assertions (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   de,
    input  wire tmds_pkg::tmds_sym_t    sym,
    input  wire tmds_pkg::disp_t        disp
);

    // set when an assertion fails
    logic   fired;

    initial begin
        fired = 1'b0;
    end

    // DVI keeps the running disparity within +-10
    disp_in_range: assert property (
        @(posedge clk) disable iff (rst) (disp >= -5'sd10) && (disp <= 5'sd10)
    ) else begin
        fired = 1'b1;
        $error("tmds disparity out of range: %0d", disp);
    end

    // control symbol after blanking input, data symbols never look like one
    ctrl_in_blank: assert property (
        @(posedge clk) disable iff (rst)
        ((sym == tmds_pkg::CTRL_00) || (sym == tmds_pkg::CTRL_01) ||
         (sym == tmds_pkg::CTRL_10) || (sym == tmds_pkg::CTRL_11)) == !$past(de)
    ) else begin
        fired = 1'b1;
        $error("tmds symbol %h does not fit the blanking state", sym);
    end

endmodule

bind tmds_encoder tmds_encoder_assertions u_enc_assert (
    .clk    (clk),
    .rst    (rst),
    .de     (de),
    .sym    (sym),
    .disp   (disp)
);

`default_nettype wire

/* tb_hdmi_sample.sv */
//////////////////////////////
// HDMI sample testbench
// frame model, pixel table and
// TMDS decode checks over one frame
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "video_defines.svh"

module tb_hdmi_sample;

    localparam int FRAME_CYCLES   = `H_TOTAL * `V_TOTAL;
    // one frame plus two lines, plus reset margin
    localparam int TIMEOUT_CYCLES = `H_TOTAL * (`V_TOTAL + 2) + 16;
    localparam int TAB_LEN        = 16;

    logic                   clk;
    logic                   rst;
    logic                   draw_hsync;
    logic                   draw_vsync;
    logic                   draw_de;
    video_pkg::rgb_t        draw_rgb;
    tmds_pkg::tmds_sym_t    tmds_ch0;
    tmds_pkg::tmds_sym_t    tmds_ch1;
    tmds_pkg::tmds_sym_t    tmds_ch2;

    int                     n;
    int                     cycles;
    logic                   full_row [0:`V_TOTAL-1];
    int                     tab_x    [TAB_LEN];
    int                     tab_y    [TAB_LEN];
    video_pkg::rgb_t        tab_rgb  [TAB_LEN];

    // model values of the previous draw cycle
    logic                   prev_de;
    logic                   prev_hs;
    logic                   prev_vs;
    int                     prev_x;
    int                     prev_y;

    tb_clock u_clk (
        .clk    (clk)
    );

    hdmi_sample_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .draw_hsync (draw_hsync),
        .draw_vsync (draw_vsync),
        .draw_de    (draw_de),
        .draw_rgb   (draw_rgb),
        .tmds_ch0   (tmds_ch0),
        .tmds_ch1   (tmds_ch1),
        .tmds_ch2   (tmds_ch2)
    );

    task automatic stop_on_failure();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_rgb(string name, video_pkg::rgb_t got, video_pkg::rgb_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_sym(string name, tmds_pkg::tmds_sym_t got, tmds_pkg::tmds_sym_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h at n=%0d", name, got, exp, n);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h at n=%0d", name, got, exp, n);
            stop_on_failure();
        end
    endtask

    // bound encoder checkers raise a flag on failure
    task automatic check_assertions();
        if (dut0.u_enc0.u_enc_assert.fired || dut0.u_enc1.u_enc_assert.fired ||
            dut0.u_enc2.u_enc_assert.fired) begin
            $display("A TMDS encoder assertion failed at n=%0d", n);
            stop_on_failure();
        end
    endtask

    function automatic logic model_de(int x, int y);
        return (x < `H_ACTIVE) && (y < `V_ACTIVE);
    endfunction

    function automatic logic model_sync(int pos, int start, int width);
        return ((pos >= start) && (pos < start + width)) ? `SYNC_POL : ~`SYNC_POL;
    endfunction

    // bar bits select red, green and blue, border wins
    function automatic video_pkg::rgb_t model_rgb(int x, int y);
        logic [2:0] bar;
        if (!model_de(x, y)) begin
            return '0;
        end
        if ((x == 0) || (x == `H_ACTIVE - 1) || (y == 0) || (y == `V_ACTIVE - 1)) begin
            return `BORDER_RGB;
        end
        bar = 3'(x / `BAR_WIDTH);
        return {{8{bar[2]}}, {8{bar[1]}}, {8{bar[0]}}};
    endfunction

    function automatic tmds_pkg::tmds_sym_t ctrl_symbol(logic c1, logic c0);
        case ({c1, c0})
            2'b00:   return tmds_pkg::CTRL_00;
            2'b01:   return tmds_pkg::CTRL_01;
            2'b10:   return tmds_pkg::CTRL_10;
            default: return tmds_pkg::CTRL_11;
        endcase
    endfunction

    // DVI receiver rule: undo inversion, then undo xor/xnor chain
    function automatic video_pkg::comp_t decode_sym(tmds_pkg::tmds_sym_t s);
        logic [7:0]         d;
        video_pkg::comp_t   b;
        d = s[9] ? ~s[7:0] : s[7:0];
        b[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            b[i] = s[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
        end
        return b;
    endfunction

    // clocks since reset released
    always @(posedge clk) begin
        if (!rst) begin
            n <= n + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the frame did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_failure();
        end
    end

    always @(negedge clk) begin
        check_assertions();
    end

    // per cycle checks, draw at n-1 and symbols at n-2
    always @(negedge clk) begin
        int                 p;
        int                 px;
        int                 py;
        logic               e_de;
        logic               e_hs;
        logic               e_vs;
        video_pkg::rgb_t    dec;
        if (!rst && (n == 0)) begin
            check_bit("draw_de", draw_de, 1'b0);
            check_bit("draw_hsync", draw_hsync, ~`SYNC_POL);
            check_bit("draw_vsync", draw_vsync, ~`SYNC_POL);
            check_rgb("draw_rgb after reset", draw_rgb, '0);
            check_sym("tmds_ch0", tmds_ch0, tmds_pkg::CTRL_00);
            check_sym("tmds_ch1", tmds_ch1, tmds_pkg::CTRL_00);
            check_sym("tmds_ch2", tmds_ch2, tmds_pkg::CTRL_00);
            prev_de = 1'b0;
            prev_hs = ~`SYNC_POL;
            prev_vs = ~`SYNC_POL;
        end else if (!rst && (n > 0)) begin
            p    = n - 1;
            px   = p % `H_TOTAL;
            py   = (p / `H_TOTAL) % `V_TOTAL;
            e_de = model_de(px, py);
            e_hs = model_sync(px, `H_ACTIVE + `H_FRONT, `H_SYNC);
            e_vs = model_sync(py, `V_ACTIVE + `V_FRONT, `V_SYNC);
            check_bit("draw_de", draw_de, e_de);
            check_bit("draw_hsync", draw_hsync, e_hs);
            check_bit("draw_vsync", draw_vsync, e_vs);
            if (!e_de) begin
                check_rgb("draw_rgb in blanking", draw_rgb, '0);
            end
            if (!prev_de) begin
                check_sym("tmds_ch0", tmds_ch0, ctrl_symbol(prev_vs, prev_hs));
                check_sym("tmds_ch1", tmds_ch1, tmds_pkg::CTRL_00);
                check_sym("tmds_ch2", tmds_ch2, tmds_pkg::CTRL_00);
            end else if (full_row[prev_y]) begin
                dec = {decode_sym(tmds_ch2), decode_sym(tmds_ch1), decode_sym(tmds_ch0)};
                check_rgb("decoded tmds", dec, model_rgb(prev_x, prev_y));
            end
            prev_de = e_de;
            prev_hs = e_hs;
            prev_vs = e_vs;
            prev_x  = px;
            prev_y  = py;
        end
    end

    initial begin
        int seed;
        int unused;
        rst    = 1'b1;
        n      = 0;
        cycles = 0;
        seed   = 68;
        unused = $urandom(seed);

        // positions in frame order, colours from the bar and border rules
        tab_x   = '{0, 320, 639, 40, 120, 200, 280, 360, 440, 520, 600, 0, 700, 0, 639, 100};
        tab_y   = '{0, 0, 0, 100, 100, 100, 100, 100, 100, 100, 100, 240, 240, 479, 479, 500};
        tab_rgb = '{24'hFFFFFF, 24'hFFFFFF, 24'hFFFFFF, 24'h000000,
                    24'h0000FF, 24'h00FF00, 24'h00FFFF, 24'hFF0000,
                    24'hFF00FF, 24'hFFFF00, 24'hFFFFFF, 24'hFFFFFF,
                    24'h000000, 24'hFFFFFF, 24'hFFFFFF, 24'h000000};

        // rows that get a full symbol decode
        for (int r = 0; r < `V_TOTAL; r++) begin
            full_row[r] = 1'b0;
        end
        full_row[0]             = 1'b1;
        full_row[`V_ACTIVE - 1] = 1'b1;
        repeat (4) begin
            full_row[1 + ($urandom % (`V_ACTIVE - 2))] = 1'b1;
        end

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < TAB_LEN; i++) begin
            while (n - 1 != tab_y[i] * `H_TOTAL + tab_x[i]) begin
                @(negedge clk);
            end
            check_rgb($sformatf("draw_rgb at %0d,%0d", tab_x[i], tab_y[i]),
                      draw_rgb, tab_rgb[i]);
        end

        // let the checks cover the last pixel's symbol
        while (n < FRAME_CYCLES + 2) begin
            @(negedge clk);
        end

        check_assertions();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
video_pkg.sv
tmds_pkg.sv
video_if.sv
video_sync_gen.sv
pattern_draw.sv
tmds_encoder.sv
hdmi_sample_top.sv
tb_clock.sv
tb_hdmi_assertions.sv
tb_hdmi_sample.sv

/* Bender.yml */
package:
  name: hdmi_sample

sources:
  - include_dirs:
      - .
    files:
      - video_pkg.sv
      - tmds_pkg.sv
      - video_if.sv
      - video_sync_gen.sv
      - pattern_draw.sv
      - tmds_encoder.sv
      - hdmi_sample_top.sv
      - target: test
        files:
          - tb_clock.sv
          - tb_hdmi_assertions.sv
          - tb_hdmi_sample.sv
